//--- compile.f
+incdir+hw
hw/vid_pkg.sv
hw/vid_timing.sv
hw/vid_char_layer.sv
hw/vid_obj_layer.sv
hw/vid_colmix.sv
hw/vid_top.sv
tests/vid_tb.sv

//--- Makefile
# Verilator build and run of the video subsystem testbench

VERILATOR ?= verilator
TOP       ?= vid_tb
RTL_TOP   ?= vid_top
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/vid_tb.sv
/*
  Directed testbench for vid_top with pxl_cen at half the clock rate.
  ROM models answer ok two clocks after the address changes, so both fetch limits hold.
  Expected pixels come from the mirrored map, sprite and palette contents and the ROMs.
*/
`timescale 1ns/1ps
`include "vid_params.svh"

module vid_tb import vid_pkg::*; ();

    localparam int UNIT_CHAR   = 0;
    localparam int UNIT_OBJ    = 1;
    localparam int UNIT_PAL    = 2;
    localparam int FRAME_PX    = `VID_H_ACTIVE * `VID_V_ACTIVE;
    localparam int FRAME_CLKS  = `VID_H_TOTAL * `VID_V_TOTAL * 2;
    localparam int CYCLE_LIMIT = 4 * FRAME_CLKS * 5 + 2 * FRAME_CLKS;

    logic       clk = 1'b0;
    logic       pxl_cen = 1'b0;
    logic       rst_n;
    logic       video_en;
    cpu_addr_t  cpu_addr;
    cpu_word_t  cpu_dout;
    logic       cpu_we;
    logic       char_cs;
    logic       obj_cs;
    logic       pal_cs;
    cpu_word_t  char_dout;
    cpu_word_t  obj_dout;
    cpu_word_t  pal_dout;
    gfx_addr_t  char_addr;
    gfx_row_t   char_data = '0;
    logic       char_ok = 1'b0;
    logic       obj_rom_cs;
    gfx_addr_t  obj_addr;
    gfx_row_t   obj_data = '0;
    logic       obj_ok = 1'b0;
    logic       hs;
    logic       vs;
    logic       vint;
    logic       hblank_n;
    logic       vblank_n;
    vcnt_t      vdump;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;

    gfx_row_t   char_rom [4096];
    gfx_row_t   obj_rom [4096];
    cpu_word_t  map_mem [`VID_MAP_COLS * `VID_MAP_ROWS];
    cpu_word_t  obj_mem [4 * `VID_OBJ_NUM];
    cpu_word_t  pal_mem [256];
    rgb_t       frame [FRAME_PX];
    gfx_addr_t  char_last = '0;
    gfx_addr_t  obj_last = '0;
    logic       char_pend = 1'b0;
    logic       obj_pend = 1'b0;
    int         seed;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    vid_top dut0 (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .video_en(video_en),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_we(cpu_we),
        .char_cs(char_cs), .obj_cs(obj_cs), .pal_cs(pal_cs),
        .char_dout(char_dout), .obj_dout(obj_dout), .pal_dout(pal_dout),
        .char_addr(char_addr), .char_data(char_data), .char_ok(char_ok),
        .obj_rom_cs(obj_rom_cs), .obj_addr(obj_addr), .obj_data(obj_data), .obj_ok(obj_ok),
        .hs(hs), .vs(vs), .vint(vint), .hblank_n(hblank_n), .vblank_n(vblank_n),
        .vdump(vdump), .red(red), .green(green), .blue(blue)
    );

    always #2 clk = ~clk;

    always @(negedge clk) pxl_cen <= ~pxl_cen;  // One enable every other clock

    // ROM models drop ok on a new address and raise it two clocks later
    always @(negedge clk) begin
        if (char_addr != char_last) begin
            char_last <= char_addr;
            char_ok   <= 1'b0;
            char_pend <= 1'b1;
        end else if (char_pend) begin
            char_pend <= 1'b0;
            char_ok   <= 1'b1;
            char_data <= char_rom[char_last];
        end
    end

    always @(negedge clk) begin
        if (obj_addr != obj_last) begin
            obj_last <= obj_addr;
            obj_ok   <= 1'b0;
            obj_pend <= 1'b1;
        end else if (obj_pend && obj_rom_cs) begin  // Object ROM answers only when selected
            obj_pend <= 1'b0;
            obj_ok   <= 1'b1;
            obj_data <= obj_rom[obj_last];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, mismatches %0d, other errors 1", checks, errors);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input cpu_word_t exp, input cpu_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic write_word(input int unit, input cpu_addr_t addr, input cpu_word_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        char_cs  = (unit == UNIT_CHAR);
        obj_cs   = (unit == UNIT_OBJ);
        pal_cs   = (unit == UNIT_PAL);
        @(negedge clk);
        {char_cs, obj_cs, pal_cs, cpu_we} = 4'b0000;
        case (unit)
            UNIT_CHAR: map_mem[addr[4:0]] = data;
            UNIT_OBJ:  obj_mem[addr[3:0]] = data;
            default:   pal_mem[addr] = data;
        endcase
    endtask

    task automatic read_word(input int unit, input cpu_addr_t addr, output cpu_word_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_we   = 1'b0;
        char_cs  = (unit == UNIT_CHAR);
        obj_cs   = (unit == UNIT_OBJ);
        pal_cs   = (unit == UNIT_PAL);
        @(negedge clk);
        {char_cs, obj_cs, pal_cs} = 3'b000;
        case (unit)
            UNIT_CHAR: data = char_dout;
            UNIT_OBJ:  data = obj_dout;
            default:   data = pal_dout;
        endcase
    endtask

    // Returns at the falling edge after the next pixel enable
    task automatic next_pixel();
        logic en;
        en = 1'b0;
        while (!en) begin
            @(posedge clk);
            en = pxl_cen;
        end
        @(negedge clk);
    endtask

    task automatic capture_frame(input string name);
        logic prev_vb;
        logic seen_fall;
        int   n;
        rgb_t px;
        prev_vb   = 1'b0;
        seen_fall = 1'b0;
        n         = 0;
        while (!seen_fall) begin
            next_pixel();
            seen_fall = prev_vb && !vblank_n;
            prev_vb   = vblank_n;
        end
        while (n < FRAME_PX) begin
            next_pixel();
            px = {red, green, blue};
            if (hblank_n && vblank_n) begin
                frame[n] = px;
                n++;
            end else begin
                check_rgb({name, " during blanking"}, '0, px);
            end
        end
    endtask

    // Lowest-numbered sprite with a solid pixel wins, else the character tile
    function automatic rgb_t expected_pixel(input int x, input int y);
        rgb_t      result;
        cpu_word_t w;
        gfx_row_t  row;
        pxl_t      nib;
        pal_idx_t  idx;
        logic      found;
        int        s;
        int        dx;
        int        dy;
        w      = map_mem[(y / 8) * `VID_MAP_COLS + x / 8];
        row    = char_rom[{1'b0, w[7:0], 3'(y)}];
        nib    = pxl_t'(row >> (28 - 4 * (x % 8)));
        idx    = {1'b0, w[10:8], nib};
        result = pal_mem[idx][14:0];
        found  = 1'b0;
        for (s = 0; s < `VID_OBJ_NUM; s++) begin
            dx = x - int'(obj_mem[4*s][7:0]);
            dy = y - int'(obj_mem[4*s+1][7:0]);
            if (!found && dx >= 0 && dx < 8 && dy >= 0 && dy < 8) begin
                row = obj_rom[{1'b0, obj_mem[4*s+2][7:0], 3'(dy)}];
                nib = pxl_t'(row >> (28 - 4 * dx));
                if (nib != 4'h0) begin
                    idx    = {1'b1, obj_mem[4*s+3][2:0], nib};
                    result = pal_mem[idx][14:0];
                    found  = 1'b1;
                end
            end
        end
        return result;
    endfunction

    task automatic compare_frame(input string name);
        int x;
        int y;
        for (y = 0; y < `VID_V_ACTIVE; y++) begin
            for (x = 0; x < `VID_H_ACTIVE; x++)
                check_rgb($sformatf("%s x=%0d y=%0d", name, x, y), expected_pixel(x, y),
                          frame[y * `VID_H_ACTIVE + x]);
        end
    endtask

    task automatic reset_state();
        check_count("hs after reset", 0, int'(hs));
        check_count("vs after reset", 0, int'(vs));
        check_count("vint after reset", 0, int'(vint));
        check_count("hblank_n after reset", 0, int'(hblank_n));
        check_count("vblank_n after reset", 0, int'(vblank_n));
        check_count("obj_rom_cs after reset", 0, int'(obj_rom_cs));
        check_rgb("rgb after reset", '0, {red, green, blue});
    endtask

    task automatic run_timing();
        int   i;
        int   hs_pulses;
        int   vs_pulses;
        int   vint_pulses;
        int   lines;
        int   run_len;
        logic en;
        logic prev_hs;
        logic prev_vs;
        hs_pulses   = 0;
        vs_pulses   = 0;
        vint_pulses = 0;
        lines       = 0;
        run_len     = 0;
        do @(negedge clk); while (!vint);  // Frame window starts at vint
        check_count("vdump at vint", `VID_V_ACTIVE, int'(vdump));
        prev_hs = hs;
        prev_vs = vs;
        for (i = 0; i < FRAME_CLKS; i++) begin
            @(posedge clk);
            en = pxl_cen;
            @(negedge clk);
            if (hs && !prev_hs) begin
                // Window opens on line VID_V_ACTIVE, one sync per line
                check_count("vdump at hsync", (`VID_V_ACTIVE + hs_pulses) % `VID_V_TOTAL,
                            int'(vdump));
                hs_pulses++;
            end
            vs_pulses   += int'(vs && !prev_vs);
            vint_pulses += int'(vint);
            prev_hs = hs;
            prev_vs = vs;
            if (en && hblank_n && vblank_n) begin
                run_len++;
            end else if (en && run_len != 0) begin
                check_count("active pixels per line", `VID_H_ACTIVE, run_len);
                lines++;
                run_len = 0;
            end
        end
        check_count("hs pulses per frame", `VID_V_TOTAL, hs_pulses);
        check_count("vs pulses per frame", 1, vs_pulses);
        check_count("active lines per frame", `VID_V_ACTIVE, lines);
        check_count("vint pulses per frame", 1, vint_pulses);
    endtask

    task automatic cpu_readback();
        int        i;
        cpu_word_t got;
        for (i = 0; i < 32; i++)
            write_word(UNIT_CHAR, cpu_addr_t'(i), cpu_word_t'(16'h1000 + i * 16'h0111));
        for (i = 0; i < 16; i++)
            write_word(UNIT_OBJ, cpu_addr_t'(i), cpu_word_t'(16'ha000 + i * 5));
        for (i = 0; i < 256; i++)
            write_word(UNIT_PAL, cpu_addr_t'(i), cpu_word_t'(i * 257) ^ 16'h3c00);
        for (i = 0; i < 32; i++) begin
            read_word(UNIT_CHAR, cpu_addr_t'(i), got);
            check_word($sformatf("map word %0d", i), map_mem[i], got);
        end
        for (i = 0; i < 16; i++) begin
            read_word(UNIT_OBJ, cpu_addr_t'(i), got);
            check_word($sformatf("sprite word %0d", i), obj_mem[i], got);
        end
        for (i = 0; i < 256; i++) begin
            read_word(UNIT_PAL, cpu_addr_t'(i), got);
            check_word($sformatf("palette word %0d", i), pal_mem[i], got);
        end
    endtask

    task automatic char_frame();
        int i;
        for (i = 0; i < 32; i++)
            write_word(UNIT_CHAR, cpu_addr_t'(i), 16'($random(seed)));
        for (i = 0; i < 256; i++)
            write_word(UNIT_PAL, cpu_addr_t'(i), 16'($random(seed)));
        for (i = 0; i < 16; i++) begin
            if (i % 4 == 1)
                write_word(UNIT_OBJ, cpu_addr_t'(i), 16'h00c8);  // Below the raster
            else
                write_word(UNIT_OBJ, cpu_addr_t'(i), 16'($random(seed)));
        end
        capture_frame("char frame");
        compare_frame("char frame");
    endtask

    task automatic place_sprite(input int s, input int x, input int y,
                                input int code, input int pal);
        write_word(UNIT_OBJ, cpu_addr_t'(4 * s), cpu_word_t'(x));
        write_word(UNIT_OBJ, cpu_addr_t'(4 * s + 1), cpu_word_t'(y));
        write_word(UNIT_OBJ, cpu_addr_t'(4 * s + 2), cpu_word_t'(code));
        write_word(UNIT_OBJ, cpu_addr_t'(4 * s + 3), cpu_word_t'(pal));
    endtask

    task automatic sprite_frame();
        place_sprite(0, 10, 5, 8'h21, 5);
        place_sprite(1, 14, 8, 8'h47, 2);   // Overlaps sprite 0
        place_sprite(2, 12, 3, 8'h9c, 7);   // Under both
        place_sprite(3, 60, 26, 8'he5, 3);  // Clipped at the right edge
        capture_frame("sprite frame");
        compare_frame("sprite frame");
    endtask

    task automatic blank_frame();
        int i;
        @(negedge clk);
        video_en = 1'b0;
        capture_frame("video off");
        for (i = 0; i < FRAME_PX; i++)
            check_rgb($sformatf("video off pixel %0d", i), '0, frame[i]);
        @(negedge clk);
        video_en = 1'b1;
    endtask

    initial begin
        rst_n    = 1'b0;
        video_en = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_we   = 1'b0;
        char_cs  = 1'b0;
        obj_cs   = 1'b0;
        pal_cs   = 1'b0;
        seed     = 32'ha34b_00e4;
        for (int i = 0; i < 4096; i++)
            char_rom[i] = gfx_row_t'($random(seed));
        for (int i = 0; i < 4096; i++)
            obj_rom[i] = gfx_row_t'($random(seed) & $random(seed));  // More clear pixels
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        run_timing();
        cpu_readback();
        char_frame();
        sprite_frame();
        blank_frame();
        $display("checks %0d, mismatches %0d, other errors 0", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- hw/vid_top.sv
/*
  Video subsystem top: timing, character layer, object layer and colour mixer.
  CPU strobes are plain selects with full-word writes; ROM ports use an ok level.
*/
`timescale 1ns/1ps

module vid_top import vid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       video_en,
    // CPU
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    input  logic       cpu_we,
    input  logic       char_cs,
    input  logic       obj_cs,
    input  logic       pal_cs,
    output cpu_word_t  char_dout,
    output cpu_word_t  obj_dout,
    output cpu_word_t  pal_dout,
    // Graphics ROMs
    output gfx_addr_t  char_addr,
    input  gfx_row_t   char_data,
    input  logic       char_ok,
    output logic       obj_rom_cs,
    output gfx_addr_t  obj_addr,
    input  gfx_row_t   obj_data,
    input  logic       obj_ok,
    // Video
    output logic       hs,
    output logic       vs,
    output logic       vint,
    output logic       hblank_n,
    output logic       vblank_n,
    output vcnt_t      vdump,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    hcnt_t      hdump;
    logic       pre_hblank_n;
    logic       pre_vblank_n;
    layer_pxl_t char_pxl;
    layer_pxl_t obj_pxl;

    vid_timing u_timing (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .hdump        ( hdump        ),
        .vdump        ( vdump        ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .pre_hblank_n ( pre_hblank_n ),
        .pre_vblank_n ( pre_vblank_n ),
        .vint         ( vint         ),
        .line_start   (              )
    );

    vid_char_layer u_char (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .char_cs   ( char_cs   ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .char_ok   ( char_ok   ),
        .char_data ( char_data ),
        .char_dout ( char_dout ),
        .char_addr ( char_addr ),
        .char_pxl  ( char_pxl  )
    );

    vid_obj_layer u_obj (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .hdump        ( hdump        ),
        .vdump        ( vdump        ),
        .pre_hblank_n ( pre_hblank_n ),
        .obj_cs       ( obj_cs       ),
        .cpu_we       ( cpu_we       ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .obj_ok       ( obj_ok       ),
        .obj_data     ( obj_data     ),
        .obj_dout     ( obj_dout     ),
        .obj_rom_cs   ( obj_rom_cs   ),
        .obj_addr     ( obj_addr     ),
        .obj_pxl      ( obj_pxl      )
    );

    vid_colmix u_colmix (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .video_en     ( video_en     ),
        .pre_hblank_n ( pre_hblank_n ),
        .pre_vblank_n ( pre_vblank_n ),
        .char_pxl     ( char_pxl     ),
        .obj_pxl      ( obj_pxl      ),
        .pal_cs       ( pal_cs       ),
        .cpu_we       ( cpu_we       ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .pal_dout     ( pal_dout     ),
        .hblank_n     ( hblank_n     ),
        .vblank_n     ( vblank_n     ),
        .red          ( red          ),
        .green        ( green        ),
        .blue         ( blue         )
    );

endmodule

//--- hw/vid_colmix.sv
/*
  Colour mixer with a 256-word palette, 5:5:5 in bits 14:0.
  Objects win over characters wherever their colour is non-zero.
  Output is black during blanking and while video_en is low.
*/
`timescale 1ns/1ps

module vid_colmix import vid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       video_en,
    input  logic       pre_hblank_n,
    input  logic       pre_vblank_n,
    input  layer_pxl_t char_pxl,
    input  layer_pxl_t obj_pxl,
    input  logic       pal_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    output cpu_word_t  pal_dout,
    output logic       hblank_n,
    output logic       vblank_n,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    cpu_word_t  pal_ram [256];
    pal_idx_t   pal_idx;
    logic [4:0] hb_sr;
    logic [4:0] vb_sr;
    rgb_t       rgb;

    always_ff @(posedge clk) begin
        if (pal_cs && cpu_we)
            pal_ram[cpu_addr] <= cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            pal_dout <= '0;
        else if (pal_cs)
            pal_dout <= pal_ram[cpu_addr];
    end

    assign pal_idx = (obj_pxl[3:0] != '0) ? {1'b1, obj_pxl} : {1'b0, char_pxl};

    // Blanking follows the four-enable layer delay plus the RGB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hb_sr <= '0;
            vb_sr <= '0;
            rgb   <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[3:0], pre_hblank_n};
            vb_sr <= {vb_sr[3:0], pre_vblank_n};
            if (hb_sr[3] && vb_sr[3] && video_en)
                rgb <= pal_ram[pal_idx][14:0];
            else
                rgb <= '0;
        end
    end

    assign hblank_n = hb_sr[4];
    assign vblank_n = vb_sr[4];
    assign red      = rgb[14:10];
    assign green    = rgb[9:5];
    assign blue     = rgb[4:0];

endmodule

//--- hw/vid_obj_layer.sv
/*
  Object layer with four sprites of 8x8 pixels, four words each: x, y, code, palette.
  The next line is built during the horizontal blank into one of two line buffers,
  so the ROM must answer each request well within the blank.
  Colour 0 is transparent. Sprite 0 has the highest priority.
*/
`timescale 1ns/1ps
`include "vid_params.svh"

module vid_obj_layer import vid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  hcnt_t      hdump,
    input  vcnt_t      vdump,
    input  logic       pre_hblank_n,
    input  logic       obj_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    input  logic       obj_ok,
    input  gfx_row_t   obj_data,
    output cpu_word_t  obj_dout,
    output logic       obj_rom_cs,
    output gfx_addr_t  obj_addr,
    output layer_pxl_t obj_pxl
);

    localparam int IW = $clog2(`VID_OBJ_NUM);
    localparam logic [IW-1:0] IDX_LAST = IW'(`VID_OBJ_NUM - 1);

    cpu_word_t  obj_ram [4 * `VID_OBJ_NUM];
    layer_pxl_t line_buf [2][`VID_H_TOTAL];
    layer_pxl_t rd_pipe [4];
    obj_state_t state;
    logic [IW-1:0] obj_idx;
    logic       line_sel;   // Buffer being shown
    logic       hb_last;
    logic       settle;
    vcnt_t      nv;
    logic [7:0] spr_dy;
    logic       covers;
    logic [7:0] spr_x;
    logic [2:0] spr_pal;
    gfx_row_t   spr_row;
    logic [8:0] wr_pos [8];
    pxl_t       wr_nib [8];

    always_ff @(posedge clk) begin
        if (obj_cs && cpu_we)
            obj_ram[cpu_addr[IW+1:0]] <= cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            obj_dout <= '0;
        else if (obj_cs)
            obj_dout <= obj_ram[cpu_addr[IW+1:0]];
    end

    // Coverage test for the line after this one
    assign nv     = (vdump == vcnt_t'(`VID_V_TOTAL - 1)) ? '0 : vdump + 1'b1;
    assign spr_dy = {2'b00, nv} - obj_ram[{obj_idx, 2'd1}][7:0];
    assign covers = (spr_dy < 8'd8);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= obj_idle;
            obj_idx    <= '0;
            obj_rom_cs <= 1'b0;
            settle     <= 1'b0;
            hb_last    <= 1'b0;
            line_sel   <= 1'b0;
        end else begin
            hb_last <= pre_hblank_n;
            settle  <= 1'b0;
            if (pxl_cen && hdump == hcnt_t'(`VID_H_TOTAL - 1))
                line_sel <= ~line_sel;
            case (state)
                obj_idle: begin
                    if (hb_last && !pre_hblank_n) begin
                        obj_idx <= IDX_LAST;  // Highest number first
                        state   <= obj_scan;
                    end
                end
                obj_scan: begin
                    if (covers) begin
                        obj_rom_cs <= 1'b1;
                        settle     <= 1'b1;
                        state      <= obj_fetch;
                    end else if (obj_idx == '0) begin
                        state <= obj_done;
                    end else begin
                        obj_idx <= obj_idx - 1'b1;
                    end
                end
                obj_fetch: begin
                    if (!settle && obj_ok) begin
                        obj_rom_cs <= 1'b0;
                        state      <= obj_write;
                    end
                end
                obj_write: begin
                    if (obj_idx == '0) begin
                        state <= obj_done;
                    end else begin
                        obj_idx <= obj_idx - 1'b1;
                        state   <= obj_scan;
                    end
                end
                obj_done: state <= obj_idle;
                default:  state <= obj_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == obj_scan && covers) begin
            obj_addr <= {1'b0, obj_ram[{obj_idx, 2'd2}][7:0], spr_dy[2:0]};
            spr_x    <= obj_ram[{obj_idx, 2'd0}][7:0];
            spr_pal  <= obj_ram[{obj_idx, 2'd3}][2:0];
        end
        if (state == obj_fetch && !settle && obj_ok)
            spr_row <= obj_data;
    end

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            wr_pos[k] = {1'b0, spr_x} + 9'(k);
            wr_nib[k] = spr_row[31 - 4*k -: 4];
        end
    end

    // Shown buffer is read and cleared, the other one is filled
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_pipe[0] <= line_buf[line_sel][hdump];
            line_buf[line_sel][hdump] <= '0;
            for (int i = 1; i < 4; i++)
                rd_pipe[i] <= rd_pipe[i-1];
        end
        if (state == obj_write) begin
            for (int k = 0; k < 8; k++) begin
                if (wr_pos[k] < 9'(`VID_H_TOTAL) && wr_nib[k] != '0)
                    line_buf[~line_sel][wr_pos[k][6:0]] <= {spr_pal, wr_nib[k]};
            end
        end
    end

    assign obj_pxl = rd_pipe[3];  // Four enables behind hdump

endmodule

//--- hw/vid_char_layer.sv
/*
  Character layer over an 8x4 map of 8x8 tiles.
  Pixel h appears on char_pxl four pixel enables after hdump is h.
  The ROM must return ok within 8 pixel enables of a request, and ok is
  ignored in the clock right after the address changes.
*/
`timescale 1ns/1ps
`include "vid_params.svh"

module vid_char_layer import vid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  hcnt_t      hdump,
    input  vcnt_t      vdump,
    input  logic       char_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    input  logic       char_ok,
    input  gfx_row_t   char_data,
    output cpu_word_t  char_dout,
    output gfx_addr_t  char_addr,
    output layer_pxl_t char_pxl
);

    cpu_word_t  map_ram [`VID_MAP_COLS * `VID_MAP_ROWS];
    cpu_word_t  map_word;
    logic [7:0] nh_raw;
    hcnt_t      nh;
    vcnt_t      nv;
    logic       tile_edge;
    logic       busy;
    logic       settle;
    logic [2:0] fetch_pal;
    logic [2:0] shift_pal;
    gfx_row_t   row_buf;
    gfx_row_t   shift;

    // CPU port
    always_ff @(posedge clk) begin
        if (char_cs && cpu_we)
            map_ram[cpu_addr[4:0]] <= cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            char_dout <= '0;
        else if (char_cs)
            char_dout <= map_ram[cpu_addr[4:0]];
    end

    // Position of the tile loaded at the next boundary, five pixels ahead
    always_comb begin
        nh_raw = {1'b0, hdump} + 8'd5;
        nh     = hcnt_t'(nh_raw);
        nv     = vdump;
        if (nh_raw >= 8'(`VID_H_TOTAL)) begin
            nh = hcnt_t'(nh_raw - 8'(`VID_H_TOTAL));
            nv = (vdump == vcnt_t'(`VID_V_TOTAL - 1)) ? '0 : vdump + 1'b1;
        end
    end

    assign map_word  = map_ram[{nv[4:3], nh[5:3]}];
    assign tile_edge = pxl_cen && (hdump[2:0] == 3'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            settle <= 1'b0;
        end else begin
            settle <= 1'b0;
            if (tile_edge) begin
                busy   <= 1'b1;
                settle <= 1'b1; // Old ok may still be high
            end else if (busy && !settle && char_ok) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_edge) begin
            char_addr <= {1'b0, map_word[7:0], nv[2:0]};
            fetch_pal <= map_word[10:8];
            shift     <= row_buf;
            shift_pal <= fetch_pal;  // Palette of the tile fetched last
        end else if (pxl_cen) begin
            shift <= shift << 4;
        end
        if (busy && !settle && char_ok)
            row_buf <= char_data;
    end

    assign char_pxl = {shift_pal, pxl_t'(shift[31:28])};

endmodule

//--- hw/vid_timing.sv
/*
  Raster counters advance on pxl_cen only.
  Sync, blanking and line_start are decoded from the counters; vint is a one-clock
  pulse just after the counters enter line VID_V_ACTIVE.
*/
`timescale 1ns/1ps
`include "vid_params.svh"

module vid_timing import vid_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pxl_cen,
    output hcnt_t hdump,
    output vcnt_t vdump,
    output logic  hs,
    output logic  vs,
    output logic  pre_hblank_n,
    output logic  pre_vblank_n,
    output logic  vint,
    output logic  line_start
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
            vint  <= 1'b0;
        end else begin
            vint <= 1'b0;
            if (pxl_cen) begin
                if (hdump == hcnt_t'(`VID_H_TOTAL - 1)) begin
                    hdump <= '0;
                    if (vdump == vcnt_t'(`VID_V_TOTAL - 1))
                        vdump <= '0;
                    else
                        vdump <= vdump + 1'b1;
                    vint <= (vdump == vcnt_t'(`VID_V_ACTIVE - 1)); // Entering vblank
                end else begin
                    hdump <= hdump + 1'b1;
                end
            end
        end
    end

    assign line_start   = (hdump == '0);
    assign pre_hblank_n = (hdump < hcnt_t'(`VID_H_ACTIVE));
    assign pre_vblank_n = (vdump < vcnt_t'(`VID_V_ACTIVE));

    // Sync windows
    assign hs = (hdump >= hcnt_t'(`VID_HS_START)) &&
                (hdump <  hcnt_t'(`VID_HS_START + `VID_HS_LEN));
    assign vs = (vdump >= vcnt_t'(`VID_VS_START)) &&
                (vdump <  vcnt_t'(`VID_VS_START + `VID_VS_LEN));

endmodule

//--- hw/vid_pkg.sv
/*
  Shared vector types for the video blocks.
  ROM rows carry 8 pixels at 4 bits, leftmost pixel in bits 31:28.
*/
package vid_pkg;

    typedef logic [6:0]  hcnt_t;
    typedef logic [5:0]  vcnt_t;
    typedef logic [15:0] cpu_word_t;
    typedef logic [7:0]  cpu_addr_t;
    typedef logic [31:0] gfx_row_t;
    typedef logic [11:0] gfx_addr_t;   // Spare bit, tile code, row
    typedef logic [3:0]  pxl_t;
    typedef logic [6:0]  layer_pxl_t;  // Palette, colour
    typedef logic [7:0]  pal_idx_t;
    typedef logic [14:0] rgb_t;        // 5:5:5, red on top

    typedef enum logic [2:0] {
        obj_idle,
        obj_scan,
        obj_fetch,
        obj_write,
        obj_done
    } obj_state_t;

endpackage

//--- hw/vid_params.svh
/*
  Raster and layer sizes for the scaled-down video subsystem.
  The character layer assumes an 8x4 tile map and the object layer four sprites,
  so address widths elsewhere are fixed to these values.
*/
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

`define VID_H_ACTIVE 64
`define VID_H_TOTAL  80
`define VID_V_ACTIVE 32
`define VID_V_TOTAL  40
`define VID_HS_START 68
`define VID_HS_LEN   4
`define VID_VS_START 35
`define VID_VS_LEN   2
`define VID_MAP_COLS 8
`define VID_MAP_ROWS 4
`define VID_OBJ_NUM  4

`endif
